/* hdl/banked_reg_file.sv */
`include "operand_consts.svh"

module banked_reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  operand_pkg::cpu_mode_t mode,
    input  operand_pkg::word_t     pc,
    input  operand_pkg::reg_addr_t ra_n,
    input  operand_pkg::reg_addr_t ra_m,
    input  operand_pkg::reg_addr_t ra_s,
    input  logic                  we,
    input  operand_pkg::reg_addr_t wa,
    input  operand_pkg::word_t     wd,
    output operand_pkg::word_t     rd_n,
    output operand_pkg::word_t     rd_m,
    output operand_pkg::word_t     rd_s
);

    import operand_pkg::*;

    // slot layout
    // 0..14 user r0..r14, 15..21 fiq r8..r14, then r13/r14 pairs
    localparam bank_index_t USR_SP_SLOT = 5'd13;
    localparam bank_index_t FIQ_SP_SLOT = 5'd20;
    localparam bank_index_t IRQ_SP_SLOT = 5'd22;
    localparam bank_index_t SVC_SP_SLOT = 5'd24;
    localparam bank_index_t UND_SP_SLOT = 5'd26;
    localparam bank_index_t ABT_SP_SLOT = 5'd28;
    localparam bank_index_t FIQ_OFFSET  = 5'd7;

    word_t       bank [`BANK_DEPTH];
    word_t       pc_plus8;
    bank_index_t wr_slot;
    logic        wr_en;

    // r13 slot for the given mode, r14 sits right after it
    function automatic bank_index_t sp_slot(cpu_mode_t m);
        case (m)
            `MODE_USR: return USR_SP_SLOT;
            `MODE_FIQ: return FIQ_SP_SLOT;
            `MODE_IRQ: return IRQ_SP_SLOT;
            `MODE_SVC: return SVC_SP_SLOT;
            `MODE_UND: return UND_SP_SLOT;
            `MODE_ABT: return ABT_SP_SLOT;
            default:   return USR_SP_SLOT;
        endcase
    endfunction

    // architectural number plus mode to physical slot
    function automatic bank_index_t slot_of(cpu_mode_t m, reg_addr_t a);
        bank_index_t slot;
        slot = bank_index_t'(a);
        if (a == 4'd13 || a == 4'd14) begin
            slot = sp_slot(m) + bank_index_t'(a == 4'd14);
        end else if (m == `MODE_FIQ && a >= 4'd8 && a != `PC_REG) begin
            slot = bank_index_t'(a) + FIQ_OFFSET;
        end
        return slot;
    endfunction

    // r15 is not stored, it reads as pc + 8
    function automatic word_t read_port(cpu_mode_t m, reg_addr_t a);
        if (a == `PC_REG) begin
            return pc_plus8;
        end
        return bank[slot_of(m, a)];
    endfunction

    assign pc_plus8 = pc + `PC_READ_OFFSET;

    //////////////////////////////
    // read ports

    always_comb begin
        rd_n = read_port(mode, ra_n);
        rd_m = read_port(mode, ra_m);
        rd_s = read_port(mode, ra_s);
    end

    //////////////////////////////
    // write port

    // writes to pc are dropped here
    assign wr_en   = we && (wa != `PC_REG);
    assign wr_slot = slot_of(mode, wa);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `BANK_DEPTH; i++) begin
                bank[i] <= '0;
            end
        end else if (wr_en) begin
            bank[wr_slot] <= wd;
        end
    end

endmodule

/* hdl/operand_bus_if.sv */
interface operand_bus_if;

    import operand_pkg::*;

    // one decoded item per strobe
    logic       valid;
    word_t      rn_value;
    // value to shift, or the extended immediate
    word_t      base;
    shift_op_t  shift_op;
    shift_amt_t shift_amt;
    // base goes out unshifted
    logic       pass_through;

    modport producer (
        output valid, rn_value, base, shift_op, shift_amt, pass_through
    );

    modport consumer (
        input valid, rn_value, base, shift_op, shift_amt, pass_through
    );

endinterface

/* hdl/operand_decode.sv */
`include "operand_consts.svh"

module operand_decode (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instr_valid,
    input  operand_pkg::word_t     instr,
    input  operand_pkg::cpu_mode_t mode,
    input  operand_pkg::word_t     pc,
    input  logic                   reg_we,
    input  operand_pkg::reg_addr_t reg_wa,
    input  operand_pkg::word_t     reg_wd,
    operand_bus_if.producer        bus
);

    import operand_pkg::*;

    logic [1:0] op;
    logic       imm_flag;
    reg_addr_t  ra_n;
    reg_addr_t  ra_m;
    reg_addr_t  ra_s;
    word_t      rd_n;
    word_t      rd_m;
    word_t      rd_s;

    word_t      next_base;
    shift_op_t  next_shift_op;
    shift_amt_t next_shift_amt;
    logic       next_pass;

    //////////////////////////////
    // field extraction

    assign op       = instr[27:26];
    assign imm_flag = instr[25];
    assign ra_n     = instr[19:16];
    assign ra_m     = instr[3:0];
    assign ra_s     = instr[11:8];

    banked_reg_file reg_file_i (
        .clk   (clk),
        .reset (reset),
        .mode  (mode),
        .pc    (pc),
        .ra_n  (ra_n),
        .ra_m  (ra_m),
        .ra_s  (ra_s),
        .we    (reg_we),
        .wa    (reg_wa),
        .wd    (reg_wd),
        .rd_n  (rd_n),
        .rd_m  (rd_m),
        .rd_s  (rd_s)
    );

    //////////////////////////////
    // operand 2 selection

    // default is rm passed through, covers bx and op 11
    always_comb begin
        next_base      = rd_m;
        next_shift_op  = `SH_LSL;
        next_shift_amt = '0;
        next_pass      = 1'b1;
        case (op)
            `OP_DATA: begin
                if (imm_flag) begin
                    next_base = word_t'(instr[7:0]);
                end else if (instr[7:4] != `BX_PATTERN) begin
                    next_pass     = 1'b0;
                    next_shift_op = shift_op_t'(instr[6:5]);
                    // bit 4 picks rs over the 5-bit immediate
                    if (instr[4]) begin
                        next_shift_amt = shift_amt_t'(rd_s[7:0]);
                    end else begin
                        next_shift_amt = shift_amt_t'(instr[11:7]);
                    end
                end
            end
            `OP_MEM: begin
                next_base = word_t'(instr[11:0]);
            end
            `OP_BRANCH: begin
                // word offset, sign extended
                next_base = {{6{instr[23]}}, instr[23:0], 2'b00};
            end
            `OP_OTHER: begin
                next_base = rd_m;
            end
            default: begin
                next_base = rd_m;
            end
        endcase
    end

    //////////////////////////////
    // stage 1 registers

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bus.valid <= 1'b0;
        end else begin
            bus.valid <= instr_valid;
        end
    end

    // payload only moves with a valid instruction
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            bus.rn_value     <= rd_n;
            bus.base         <= next_base;
            bus.shift_op     <= next_shift_op;
            bus.shift_amt    <= next_shift_amt;
            bus.pass_through <= next_pass;
        end
    end

endmodule

/* hdl/operand_pkg.sv */
`include "operand_consts.svh"

package operand_pkg;

    //////////////////////////////
    // datapath values

    // data word, also pc and immediates
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // architectural register number r0..r15
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // physical slot in the banked file
    typedef logic [`BANK_INDEX_WIDTH-1:0] bank_index_t;

    //////////////////////////////
    // control fields

    // current processor mode
    typedef logic [`MODE_WIDTH-1:0] cpu_mode_t;

    // lsl, lsr, asr, ror
    typedef logic [`SHIFT_OP_WIDTH-1:0] shift_op_t;

    // immediate amount or bottom byte of rs
    typedef logic [`SHIFT_AMT_WIDTH-1:0] shift_amt_t;

endpackage

/* hdl/operand_shifter.sv */
`include "operand_consts.svh"

module operand_shifter (
    input  logic               clk,
    input  logic               reset,
    operand_bus_if.consumer    bus,
    output logic               out_valid,
    output operand_pkg::word_t rn_value,
    output operand_pkg::word_t operand2
);

    import operand_pkg::*;

    localparam int ROT_BITS = $clog2(`WORD_WIDTH);

    logic [ROT_BITS-1:0]      rot;
    logic                     saturate;
    logic [2*`WORD_WIDTH-1:0] ror_wide;
    word_t                    shifted;
    word_t                    next_operand2;

    //////////////////////////////
    // barrel shifter

    // amounts of 32 and up saturate, ror only looks at the low bits
    assign rot      = bus.shift_amt[ROT_BITS-1:0];
    assign saturate = (bus.shift_amt >= shift_amt_t'(`WORD_WIDTH));
    assign ror_wide = {bus.base, bus.base} >> rot;

    always_comb begin
        shifted = bus.base;
        if (bus.shift_amt != '0) begin
            case (bus.shift_op)
                `SH_LSL: begin
                    shifted = saturate ? '0 : (bus.base << rot);
                end
                `SH_LSR: begin
                    shifted = saturate ? '0 : (bus.base >> rot);
                end
                `SH_ASR: begin
                    if (saturate) begin
                        shifted = {`WORD_WIDTH{bus.base[`WORD_WIDTH-1]}};
                    end else begin
                        shifted = word_t'($signed(bus.base) >>> rot);
                    end
                end
                `SH_ROR: begin
                    shifted = ror_wide[`WORD_WIDTH-1:0];
                end
                default: begin
                    shifted = bus.base;
                end
            endcase
        end
    end

    // immediates, bx and op 11 skip the shifter
    assign next_operand2 = bus.pass_through ? bus.base : shifted;

    //////////////////////////////
    // stage 2 registers

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= bus.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.valid) begin
            rn_value <= bus.rn_value;
            operand2 <= next_operand2;
        end
    end

endmodule

/* hdl/operand_unit.sv */
module operand_unit (
    input  logic                   clk,
    input  logic                   reset,

    // instruction side
    input  logic                   instr_valid,
    input  operand_pkg::word_t     instr,
    input  operand_pkg::cpu_mode_t mode,
    input  operand_pkg::word_t     pc,

    // write back from the core
    input  logic                   reg_we,
    input  operand_pkg::reg_addr_t reg_wa,
    input  operand_pkg::word_t     reg_wd,

    // results, two cycles after instr_valid
    output logic                   out_valid,
    output operand_pkg::word_t     rn_value,
    output operand_pkg::word_t     operand2
);

    // decode to shifter link
    operand_bus_if bus_i ();

    //////////////////////////////
    // stage 1 decode and reads

    operand_decode decode_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .mode        (mode),
        .pc          (pc),
        .reg_we      (reg_we),
        .reg_wa      (reg_wa),
        .reg_wd      (reg_wd),
        .bus         (bus_i.producer)
    );

    //////////////////////////////
    // stage 2 shift and select

    operand_shifter shifter_i (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus_i.consumer),
        .out_valid (out_valid),
        .rn_value  (rn_value),
        .operand2  (operand2)
    );

endmodule

/* include/operand_consts.svh */
`ifndef OPERAND_CONSTS_SVH
`define OPERAND_CONSTS_SVH

// datapath widths
`define WORD_WIDTH        32
`define REG_ADDR_WIDTH    4
`define BANK_INDEX_WIDTH  5
`define MODE_WIDTH        3
`define SHIFT_OP_WIDTH    2
`define SHIFT_AMT_WIDTH   8

// register file shape
`define BANK_DEPTH        30
`define PC_REG            4'd15
`define PC_READ_OFFSET    32'd8

// processor modes
`define MODE_USR          3'd0
`define MODE_FIQ          3'd1
`define MODE_IRQ          3'd2
`define MODE_SVC          3'd3
`define MODE_UND          3'd4
`define MODE_ABT          3'd5

// shift kinds, instr bits 6:5
`define SH_LSL            2'd0
`define SH_LSR            2'd1
`define SH_ASR            2'd2
`define SH_ROR            2'd3

// op field, instr bits 27:26
`define OP_DATA           2'd0
`define OP_MEM            2'd1
`define OP_BRANCH         2'd2
`define OP_OTHER          2'd3

// branch and exchange, instr bits 7:4
`define BX_PATTERN        4'b0001

`endif

/* operand_unit.f */
+incdir+include
hdl/operand_pkg.sv
hdl/operand_bus_if.sv
hdl/banked_reg_file.sv
hdl/operand_decode.sv
hdl/operand_shifter.sv
hdl/operand_unit.sv
tb/tb_operand_unit.sv

/* tb/tb_operand_unit.sv */
`include "operand_consts.svh"

module tb_operand_unit;

    import operand_pkg::*;

    logic      clk;
    logic      reset;
    logic      instr_valid;
    word_t     instr;
    cpu_mode_t mode;
    word_t     pc;
    logic      reg_we;
    reg_addr_t reg_wa;
    word_t     reg_wd;
    logic      out_valid;
    word_t     rn_value;
    word_t     operand2;

    // expected results, oldest at the front
    word_t exp_rn_q [$];
    word_t exp_op2_q [$];

    // register model: user view, fiq r8..r14, r13/r14 per mode
    word_t usr_regs [15];
    word_t fiq_regs [15];
    word_t sp_regs [6];
    word_t lr_regs [6];

    word_t rng_state;
    word_t rs_values [8];

    operand_unit dut_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .mode        (mode),
        .pc          (pc),
        .reg_we      (reg_we),
        .reg_wa      (reg_wa),
        .reg_wd      (reg_wd),
        .out_valid   (out_valid),
        .rn_value    (rn_value),
        .operand2    (operand2)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // helpers

    function automatic word_t xorshift32(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic word_t model_read(input cpu_mode_t m, input reg_addr_t r,
                                         input word_t pc_val);
        int bank;
        bank = (m <= 3'd5) ? int'(m) : 0;
        case (r)
            4'd15: return pc_val + 32'd8;
            4'd13: return sp_regs[bank];
            4'd14: return lr_regs[bank];
            default: return (m == `MODE_FIQ && r >= 4'd8) ? fiq_regs[r] : usr_regs[r];
        endcase
    endfunction

    function automatic void model_write(input cpu_mode_t m, input reg_addr_t r, input word_t d);
        int bank;
        bank = (m <= 3'd5) ? int'(m) : 0;
        // r15 is not a storage register
        if (r == 4'd13) begin
            sp_regs[bank] = d;
        end else if (r == 4'd14) begin
            lr_regs[bank] = d;
        end else if (r != 4'd15) begin
            if (m == `MODE_FIQ && r >= 4'd8) begin
                fiq_regs[r] = d;
            end else begin
                usr_regs[r] = d;
            end
        end
    endfunction

    function automatic word_t shift_ref(input word_t v, input logic [1:0] kind,
                                        input logic [7:0] amt);
        int n;
        n = int'(amt);
        if (n == 0) begin
            return v;
        end
        case (kind)
            2'd0: return (n >= 32) ? 32'd0 : v << n;
            2'd1: return (n >= 32) ? 32'd0 : v >> n;
            2'd2: begin
                if (n >= 32) begin
                    return v[31] ? 32'hffff_ffff : 32'd0;
                end
                return (v >> n) | (v[31] ? ~(32'hffff_ffff >> n) : 32'd0);
            end
            default: begin
                n = n % 32;
                return (n == 0) ? v : ((v >> n) | (v << (32 - n)));
            end
        endcase
    endfunction

    function automatic word_t expect_operand2(input word_t ins, input cpu_mode_t m,
                                              input word_t pc_val);
        word_t rm;
        word_t rs;
        word_t offset;
        rm = model_read(m, ins[3:0], pc_val);
        rs = model_read(m, ins[11:8], pc_val);
        offset = {{8{ins[23]}}, ins[23:0]};
        case (ins[27:26])
            2'b00: begin
                if (ins[25]) begin
                    return {24'd0, ins[7:0]};
                end
                if (ins[7:4] == 4'b0001) begin
                    return rm;
                end
                return shift_ref(rm, ins[6:5], ins[4] ? rs[7:0] : {3'd0, ins[11:7]});
            end
            2'b01: return {20'd0, ins[11:0]};
            2'b10: return offset << 2;
            default: return rm;
        endcase
    endfunction

    // op 11 reading r as both rn and rm
    function automatic word_t read_instr(input reg_addr_t r);
        return {4'he, 2'b11, 6'd0, r, 4'd0, 8'd0, r};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    // one cycle of inputs, read before the same-cycle write
    task automatic issue(input logic valid, input word_t ins, input cpu_mode_t m,
                         input word_t pc_val, input logic we, input reg_addr_t wa,
                         input word_t wd);
        instr_valid = valid;
        instr       = ins;
        mode        = m;
        pc          = pc_val;
        reg_we      = we;
        reg_wa      = wa;
        reg_wd      = wd;
        if (valid) begin
            exp_rn_q.push_back(model_read(m, ins[19:16], pc_val));
            exp_op2_q.push_back(expect_operand2(ins, m, pc_val));
        end
        if (we) begin
            model_write(m, wa, wd);
        end
        @(negedge clk);
    endtask

    task automatic send(input word_t ins, input cpu_mode_t m, input word_t pc_val);
        issue(1'b1, ins, m, pc_val, 1'b0, 4'd0, 32'd0);
    endtask

    task automatic write_reg(input cpu_mode_t m, input reg_addr_t a, input word_t d);
        issue(1'b0, next_rand(), m, 32'd0, 1'b1, a, d);
    endtask

    //////////////////////////////
    // checks

    latency_check: assert property (@(posedge clk) disable iff (reset)
        instr_valid |-> ##2 out_valid)
        else fail_run($sformatf("[ERROR] %0t out_valid missing 2 cycles after instr_valid",
                                $time));

    origin_check: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> $past(instr_valid, 2))
        else fail_run($sformatf("[ERROR] %0t out_valid with no instruction 2 cycles back",
                                $time));

    // outputs are registered, stable at the falling edge
    always @(negedge clk) begin
        word_t want_rn;
        word_t want_op2;
        if (!reset && out_valid) begin
            if (exp_rn_q.size() == 0) begin
                fail_run($sformatf("[ERROR] %0t out_valid with empty expected queue", $time));
            end else begin
                want_rn  = exp_rn_q.pop_front();
                want_op2 = exp_op2_q.pop_front();
                result_check: assert (rn_value == want_rn && operand2 == want_op2)
                    else fail_run($sformatf("[ERROR] %0t rn %h op2 %h, expected rn %h op2 %h",
                                            $time, rn_value, operand2, want_rn, want_op2));
            end
        end
    end

    //////////////////////////////
    // stimulus

    initial begin
        word_t w;
        word_t v;
        int n;
        rng_state   = 32'h8bb9_38cb;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        mode        = `MODE_USR;
        pc          = '0;
        reg_we      = 1'b0;
        reg_wa      = '0;
        reg_wd      = '0;
        usr_regs    = '{default: '0};
        fiq_regs    = '{default: '0};
        sp_regs     = '{default: '0};
        lr_regs     = '{default: '0};
        rs_values   = '{32'd0, 32'd1, 32'd31, 32'd32, 32'd33, 32'd200, 32'd255, 32'h0000_0125};
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk);

        // every register in every mode reads zero
        for (int m = 0; m < 6; m++) begin
            for (int r = 0; r < 16; r++) begin
                send(read_instr(reg_addr_t'(r)), cpu_mode_t'(m), next_rand() & 32'hffff_fffc);
            end
        end

        // imm8, imm12, branch offset both signs
        for (int k = 0; k < 16; k++) begin
            w = next_rand();
            case (k % 4)
                0: w[27:25] = 3'b001;
                1: w[27:26] = 2'b01;
                2: begin
                    w[27:26] = 2'b10;
                    w[23] = 1'b0;
                end
                default: begin
                    w[27:26] = 2'b10;
                    w[23] = 1'b1;
                end
            endcase
            send(w, `MODE_USR, 32'h0000_1000);
        end

        for (int r = 0; r < 15; r++) begin
            write_reg(`MODE_USR, reg_addr_t'(r), next_rand());
        end

        // immediate shift amounts, some forced to zero
        for (int k = 0; k < 48; k++) begin
            w = next_rand();
            w[27:25] = 3'b000;
            w[4] = 1'b0;
            if (k % 6 == 0) begin
                w[11:7] = 5'd0;
            end
            send(w, `MODE_USR, 32'h0000_2000);
        end

        // bx pattern and op 11 pass rm
        for (int k = 0; k < 8; k++) begin
            w = next_rand();
            w[27:25] = 3'b000;
            w[7:4] = 4'b0001;
            send(w, `MODE_USR, 32'h0000_3000);
            w = next_rand();
            w[27:26] = 2'b11;
            send(w, `MODE_USR, 32'h0000_3000);
        end

        // amounts from rs in r9; bit 7 set keeps lsl off the bx pattern
        foreach (rs_values[i]) begin
            write_reg(`MODE_USR, 4'd9, rs_values[i]);
            for (int kind = 0; kind < 4; kind++) begin
                w = next_rand();
                w[27:25] = 3'b000;
                w[11:8] = 4'd9;
                w[7] = 1'b1;
                w[6:5] = kind[1:0];
                w[4] = 1'b1;
                send(w, `MODE_USR, 32'h0000_3800);
            end
        end

        // banked writes, then r8 and r13..r15 from four modes
        write_reg(`MODE_FIQ, 4'd8, 32'h0f1a_0008);
        write_reg(`MODE_SVC, 4'd13, 32'h05c0_000d);
        write_reg(`MODE_SVC, 4'd14, 32'h05c0_000e);
        write_reg(`MODE_IRQ, 4'd13, 32'h01c0_000d);
        write_reg(`MODE_IRQ, 4'd14, 32'h01c0_000e);
        write_reg(`MODE_USR, 4'd15, 32'hdead_beef);
        for (int m = 0; m < 4; m++) begin
            for (int r = 8; r < 16; r++) begin
                send(read_instr(reg_addr_t'(r)), cpu_mode_t'(m), 32'h0000_4000 + 32'(r * 4));
            end
        end

        // back to back traffic with writes mixed in
        for (int k = 0; k < 300; k++) begin
            v = next_rand();
            issue(v[2:0] != 3'd0, next_rand(), cpu_mode_t'(v[10:8] % 3'd6),
                  next_rand() & 32'hffff_fffc, v[3], v[7:4], next_rand());
        end
        issue(1'b0, 32'd0, `MODE_USR, 32'd0, 1'b0, 4'd0, 32'd0);

        n = 0;
        while (exp_rn_q.size() != 0 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (exp_rn_q.size() != 0) begin
            fail_run("timed out waiting for the last results to come out");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule
